/* logic/iob_ic_macros.svh */
`ifndef IOB_IC_MACROS_SVH
`define IOB_IC_MACROS_SVH

////////////////////
// Slave map
////////////////////

// Number of memory slaves
`define IOB_N_SLAVES 4
// Slave index width, ceil(log2(IOB_N_SLAVES))
`define IOB_SLAVE_ADDR_W 2

////////////////////
// Bus widths
////////////////////

`define IOB_ADDR_W 32
`define IOB_DATA_W 32
`define IOB_STRB_W 4

// Word index inside one slave, address bits 5..2
`define IOB_MEM_WORDS_W 4

`endif

/* logic/iob_ic_pkg.sv */
package iob_ic_pkg;

   ////////////////////
   // Request kind
   ////////////////////

   // Write when any strobe bit is set
   typedef enum logic [0:0] {
      REQ_READ  = 1'b0,
      REQ_WRITE = 1'b1
   } iob_req_kind_t;

   ////////////////////
   // Stage state
   ////////////////////

   // Shared by decoder and fan-out FSMs
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_BUSY = 2'd1,
      ST_DONE = 2'd2
   } iob_stage_state_t;

endpackage

/* logic/iob_addr_decoder.sv */
`include "iob_ic_macros.svh"

module iob_addr_decoder (
   input  logic                          clk,
   input  logic                          reset,
   // Master request
   input  logic                          m_valid,
   input  logic [`IOB_ADDR_W-1:0]        m_addr,
   input  logic [`IOB_DATA_W-1:0]        m_wdata,
   input  logic [`IOB_STRB_W-1:0]        m_wstrb,
   input  logic                          m_ready,
   // Decoded request to fan-out
   output logic                          dec_valid,
   output logic [`IOB_SLAVE_ADDR_W-1:0]  dec_index,
   output logic [`IOB_N_SLAVES-1:0]      dec_onehot,
   output iob_ic_pkg::iob_req_kind_t     dec_kind,
   output logic [`IOB_ADDR_W-1:0]        dec_addr,
   output logic [`IOB_DATA_W-1:0]        dec_wdata,
   output logic [`IOB_STRB_W-1:0]        dec_wstrb,
   input  logic                          dec_taken
);

   import iob_ic_pkg::*;

   iob_stage_state_t state;

   // Slave index from top address bits
   logic [`IOB_SLAVE_ADDR_W-1:0] m_index;
   assign m_index = m_addr[`IOB_ADDR_W-1 -: `IOB_SLAVE_ADDR_W];

   ////////////////////
   // Control FSM
   ////////////////////

   // Idle -> busy on capture, busy -> done on take, done -> idle on m_ready
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (m_valid) state <= ST_BUSY;
            ST_BUSY: if (dec_taken) state <= ST_DONE;
            ST_DONE: if (m_ready) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Offered to fan-out only while busy
   assign dec_valid = (state == ST_BUSY);

   ////////////////////
   // Request capture
   ////////////////////

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && m_valid) begin
         dec_index  <= m_index;
         dec_onehot <= `IOB_N_SLAVES'(1) << m_index;
         // Any strobe set means write
         dec_kind   <= (|m_wstrb) ? REQ_WRITE : REQ_READ;
         dec_addr   <= m_addr;
         dec_wdata  <= m_wdata;
         dec_wstrb  <= m_wstrb;
      end
   end

endmodule

/* logic/iob_req_fanout.sv */
`include "iob_ic_macros.svh"

module iob_req_fanout (
   input  logic                                  clk,
   input  logic                                  reset,
   // Decoded request
   input  logic                                  dec_valid,
   input  logic [`IOB_SLAVE_ADDR_W-1:0]          dec_index,
   input  logic [`IOB_N_SLAVES-1:0]              dec_onehot,
   input  iob_ic_pkg::iob_req_kind_t             dec_kind,
   input  logic [`IOB_ADDR_W-1:0]                dec_addr,
   input  logic [`IOB_DATA_W-1:0]                dec_wdata,
   input  logic [`IOB_STRB_W-1:0]                dec_wstrb,
   output logic                                  dec_taken,
   // Slave side
   output logic [`IOB_N_SLAVES-1:0]              s_valid,
   output logic [`IOB_ADDR_W-1:0]                s_addr,
   output logic [`IOB_DATA_W-1:0]                s_wdata,
   output logic [`IOB_N_SLAVES*`IOB_STRB_W-1:0]  s_wstrb,
   input  logic [`IOB_N_SLAVES-1:0]              s_ready,
   // Response stage control
   output logic [`IOB_SLAVE_ADDR_W-1:0]          rsp_index,
   output logic                                  rsp_capture
);

   import iob_ic_pkg::*;

   iob_stage_state_t state;

   // Take only when idle
   assign dec_taken = (state == ST_IDLE) && dec_valid;

   // Selected slave answered
   assign rsp_capture = (state == ST_BUSY) && s_ready[rsp_index];

   ////////////////////
   // Control FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ST_IDLE;
         s_valid <= '0;
         s_wstrb <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (dec_taken) begin
                  // Valid and strobes masked by the one-hot select
                  s_valid <= dec_onehot;
                  for (int i = 0; i < `IOB_N_SLAVES; i++) begin
                     s_wstrb[i*`IOB_STRB_W +: `IOB_STRB_W] <=
                        (dec_kind == REQ_WRITE && dec_onehot[i]) ? dec_wstrb : '0;
                  end
                  state <= ST_BUSY;
               end
            end
            ST_BUSY: begin
               // Hold everything until the selected ready
               if (rsp_capture) begin
                  s_valid <= '0;
                  s_wstrb <= '0;
                  state   <= ST_DONE;
               end
            end
            // One cycle while m_ready goes out
            ST_DONE: state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   ////////////////////
   // Broadcast payload
   ////////////////////

   always_ff @(posedge clk) begin
      if (dec_taken) begin
         s_addr    <= dec_addr;
         s_wdata   <= dec_wdata;
         rsp_index <= dec_index;
      end
   end

endmodule

/* logic/iob_resp_mux.sv */
`include "iob_ic_macros.svh"

module iob_resp_mux (
   input  logic                                  clk,
   input  logic                                  reset,
   // From fan-out
   input  logic [`IOB_SLAVE_ADDR_W-1:0]          rsp_index,
   input  logic                                  rsp_capture,
   // Concatenated slave read data
   input  logic [`IOB_N_SLAVES*`IOB_DATA_W-1:0]  s_rdata,
   // Master response
   output logic [`IOB_DATA_W-1:0]                m_rdata,
   output logic                                  m_ready
);

   // Slice of the answering slave
   logic [`IOB_DATA_W-1:0] sel_rdata;
   assign sel_rdata = s_rdata[rsp_index*`IOB_DATA_W +: `IOB_DATA_W];

   ////////////////////
   // Ready pulse
   ////////////////////

   // One cycle after the slave ready
   always_ff @(posedge clk) begin
      if (reset) begin
         m_ready <= 1'b0;
      end else begin
         m_ready <= rsp_capture;
      end
   end

   ////////////////////
   // Read data
   ////////////////////

   // Held until next capture
   always_ff @(posedge clk) begin
      if (rsp_capture) begin
         m_rdata <= sel_rdata;
      end
   end

endmodule

/* logic/iob_sram_slave.sv */
`include "iob_ic_macros.svh"

module iob_sram_slave #(
   parameter int WAIT_STATES = 0
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        valid,
   // Word index inside this slave
   input  logic [`IOB_MEM_WORDS_W-1:0] addr,
   input  logic [`IOB_DATA_W-1:0]      wdata,
   input  logic [`IOB_STRB_W-1:0]      wstrb,
   output logic [`IOB_DATA_W-1:0]      rdata,
   output logic                        ready
);

   localparam int N_WORDS = 1 << `IOB_MEM_WORDS_W;
   localparam int BYTE_W  = `IOB_DATA_W / `IOB_STRB_W;
   // At least one bit even with no wait states
   localparam int CNT_W   = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   logic [`IOB_DATA_W-1:0] mem [N_WORDS];
   logic [CNT_W-1:0]       wait_cnt;

   ////////////////////
   // Wait states
   ////////////////////

   // Ready W cycles after valid rises, for one cycle
   assign ready = valid && (wait_cnt == CNT_W'(WAIT_STATES));

   always_ff @(posedge clk) begin
      if (reset) begin
         wait_cnt <= '0;
      end else if (valid && !ready) begin
         wait_cnt <= wait_cnt + 1'b1;
      end else begin
         wait_cnt <= '0;
      end
   end

   ////////////////////
   // Storage
   ////////////////////

   // Byte writes land in the ready cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int w = 0; w < N_WORDS; w++) begin
            mem[w] <= '0;
         end
      end else if (ready) begin
         for (int b = 0; b < `IOB_STRB_W; b++) begin
            if (wstrb[b]) begin
               mem[addr][b*BYTE_W +: BYTE_W] <= wdata[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   // Word before any write
   assign rdata = mem[addr];

endmodule

/* logic/iob_interconnect_top.sv */
`include "iob_ic_macros.svh"

module iob_interconnect_top (
   input  logic                    clk,
   input  logic                    reset,
   // Master native interface
   input  logic                    m_valid,
   input  logic [`IOB_ADDR_W-1:0]  m_addr,
   input  logic [`IOB_DATA_W-1:0]  m_wdata,
   input  logic [`IOB_STRB_W-1:0]  m_wstrb,
   output logic [`IOB_DATA_W-1:0]  m_rdata,
   output logic                    m_ready
);

   import iob_ic_pkg::*;

   // Wait states per slave
   localparam int SLAVE_WAITS [`IOB_N_SLAVES] = '{0, 1, 3, 5};

   ////////////////////
   // Stage wires
   ////////////////////

   // Decoder to fan-out
   logic                                  dec_valid;
   logic [`IOB_SLAVE_ADDR_W-1:0]          dec_index;
   logic [`IOB_N_SLAVES-1:0]              dec_onehot;
   iob_req_kind_t                         dec_kind;
   logic [`IOB_ADDR_W-1:0]                dec_addr;
   logic [`IOB_DATA_W-1:0]                dec_wdata;
   logic [`IOB_STRB_W-1:0]                dec_wstrb;
   logic                                  dec_taken;

   // Fan-out and slaves
   logic [`IOB_N_SLAVES-1:0]              s_valid;
   logic [`IOB_ADDR_W-1:0]                s_addr;
   logic [`IOB_DATA_W-1:0]                s_wdata;
   logic [`IOB_N_SLAVES*`IOB_STRB_W-1:0]  s_wstrb;
   logic [`IOB_N_SLAVES*`IOB_DATA_W-1:0]  s_rdata;
   logic [`IOB_N_SLAVES-1:0]              s_ready;

   // Fan-out to response stage
   logic [`IOB_SLAVE_ADDR_W-1:0]          rsp_index;
   logic                                  rsp_capture;

   ////////////////////
   // Pipeline stages
   ////////////////////

   // Stage 1, capture and decode
   iob_addr_decoder dec_i (
      .clk(clk), .reset(reset),
      .m_valid(m_valid), .m_addr(m_addr), .m_wdata(m_wdata), .m_wstrb(m_wstrb),
      .m_ready(m_ready),
      .dec_valid(dec_valid), .dec_index(dec_index), .dec_onehot(dec_onehot),
      .dec_kind(dec_kind), .dec_addr(dec_addr), .dec_wdata(dec_wdata),
      .dec_wstrb(dec_wstrb), .dec_taken(dec_taken)
   );

   // Stage 2, drive selected slave
   iob_req_fanout fan_i (
      .clk(clk), .reset(reset),
      .dec_valid(dec_valid), .dec_index(dec_index), .dec_onehot(dec_onehot),
      .dec_kind(dec_kind), .dec_addr(dec_addr), .dec_wdata(dec_wdata),
      .dec_wstrb(dec_wstrb), .dec_taken(dec_taken),
      .s_valid(s_valid), .s_addr(s_addr), .s_wdata(s_wdata), .s_wstrb(s_wstrb),
      .s_ready(s_ready),
      .rsp_index(rsp_index), .rsp_capture(rsp_capture)
   );

   // Stage 3, return data and ready
   iob_resp_mux rsp_i (
      .clk(clk), .reset(reset),
      .rsp_index(rsp_index), .rsp_capture(rsp_capture),
      .s_rdata(s_rdata),
      .m_rdata(m_rdata), .m_ready(m_ready)
   );

   ////////////////////
   // Memory slaves
   ////////////////////

   // Word index from address bits 5..2
   for (genvar g = 0; g < `IOB_N_SLAVES; g++) begin : g_slave
      iob_sram_slave #(
         .WAIT_STATES(SLAVE_WAITS[g])
      ) sram_i (
         .clk(clk), .reset(reset),
         .valid(s_valid[g]),
         .addr(s_addr[`IOB_MEM_WORDS_W+1:2]),
         .wdata(s_wdata),
         .wstrb(s_wstrb[g*`IOB_STRB_W +: `IOB_STRB_W]),
         .rdata(s_rdata[g*`IOB_DATA_W +: `IOB_DATA_W]),
         .ready(s_ready[g])
      );
   end

endmodule

/* bench/iob_ic_chk.sv */
`include "iob_ic_macros.svh"

module iob_ic_chk (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [`IOB_N_SLAVES-1:0]              s_valid,
   input  logic [`IOB_N_SLAVES-1:0]              s_ready,
   input  logic [`IOB_ADDR_W-1:0]                s_addr,
   input  logic [`IOB_DATA_W-1:0]                s_wdata,
   input  logic [`IOB_N_SLAVES*`IOB_STRB_W-1:0]  s_wstrb,
   input  logic                                  m_ready
);

   timeunit 1ns;
   timeprecision 1ps;

   // Request out and selected slave not yet ready
   logic s_waiting;
   assign s_waiting = (|s_valid) && !(|(s_valid & s_ready));

   // Count of failed assertions
   int assert_fails = 0;

   ////////////////////
   // Slave select
   ////////////////////

   valid_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(s_valid))
      else begin
         $error("more than one slave valid at once");
         assert_fails++;
      end

   ////////////////////
   // Master ready
   ////////////////////

   // Single-cycle pulse
   ready_pulse: assert property (@(posedge clk) disable iff (reset)
      m_ready |=> !m_ready)
      else begin
         $error("m_ready high for two cycles in a row");
         assert_fails++;
      end

   ////////////////////
   // Request hold
   ////////////////////

   req_stable: assert property (@(posedge clk) disable iff (reset)
      s_waiting |=> ($stable(s_valid) && $stable(s_addr) && $stable(s_wdata)
                     && $stable(s_wstrb)))
      else begin
         $error("slave request changed before the selected ready");
         assert_fails++;
      end

   // Strobes only on the selected slave
   for (genvar i = 0; i < `IOB_N_SLAVES; i++) begin : g_strb
      strb_masked: assert property (@(posedge clk) disable iff (reset)
         !s_valid[i] |-> (s_wstrb[i*`IOB_STRB_W +: `IOB_STRB_W] == '0))
         else begin
            $error("strobe set on a slave whose valid is low");
            assert_fails++;
         end
   end

endmodule

bind iob_interconnect_top iob_ic_chk chk_i (
   .clk(clk), .reset(reset),
   .s_valid(s_valid), .s_ready(s_ready),
   .s_addr(s_addr), .s_wdata(s_wdata), .s_wstrb(s_wstrb),
   .m_ready(m_ready)
);

/* bench/iob_ic_tb.sv */
`include "iob_ic_macros.svh"

module iob_ic_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int    CLK_PERIOD    = 40;
   localparam int    RESET_CYCLES  = 8;
   localparam int    DRIVE_DLY     = 2;
   localparam int    READY_TIMEOUT = 50;
   localparam string CASE_FILE     = "bench/iob_ic_cases.txt";

   logic                    clk;
   logic                    reset;
   logic                    m_valid;
   logic [`IOB_ADDR_W-1:0]  m_addr;
   logic [`IOB_DATA_W-1:0]  m_wdata;
   logic [`IOB_STRB_W-1:0]  m_wstrb;
   logic [`IOB_DATA_W-1:0]  m_rdata;
   logic                    m_ready;

   int error_count = 0;
   int pass_count  = 0;
   int fail_count  = 0;

   // Gap generator state
   logic [16:0] lfsr_q = 17'd91268;

   iob_interconnect_top dut_i (
      .clk(clk), .reset(reset),
      .m_valid(m_valid), .m_addr(m_addr), .m_wdata(m_wdata), .m_wstrb(m_wstrb),
      .m_rdata(m_rdata), .m_ready(m_ready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////
   // Random gaps
   ////////////////////

   // Fibonacci LFSR with taps 17 and 14
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   // One step per bit
   function automatic logic lfsr_bit();
      lfsr_q = lfsr_next(lfsr_q);
      return lfsr_q[0];
   endfunction

   ////////////////////
   // Checks
   ////////////////////

   task automatic check_value(input string name, input logic [`IOB_DATA_W-1:0] expected,
                              input logic [`IOB_DATA_W-1:0] actual);
      if (actual !== expected) begin
         $display("** Error: test %s expected %h actual %h", name, expected, actual);
         error_count++;
      end
   endtask

   // Sampled just after the edge where registered outputs have settled
   task automatic wait_ready(input string name, output logic got_ready);
      int cycles;
      cycles = 0;
      got_ready = 1'b0;
      while (!got_ready && cycles < READY_TIMEOUT) begin
         @(posedge clk);
         #DRIVE_DLY;
         cycles++;
         got_ready = m_ready;
      end
      if (!got_ready) begin
         $display("no ready from interconnect for test %s", name);
      end
   endtask

   ////////////////////
   // Master driver
   ////////////////////

   task automatic run_case(input string name, input string kind,
                           input logic [`IOB_ADDR_W-1:0] addr,
                           input logic [`IOB_DATA_W-1:0] wdata,
                           input logic [`IOB_STRB_W-1:0] strb,
                           input logic [`IOB_DATA_W-1:0] expected,
                           output logic timed_out);
      logic got_ready;
      int   errors_before;
      errors_before = error_count;
      m_valid = 1'b1;
      m_addr  = addr;
      m_wdata = wdata;
      // Reads go out with no strobes
      m_wstrb = (kind == "W") ? strb : '0;
      wait_ready(name, got_ready);
      m_valid = 1'b0;
      m_wstrb = '0;
      timed_out = !got_ready;
      if (!got_ready) begin
         error_count++;
      end else if (kind == "R") begin
         check_value(name, expected, m_rdata);
      end
      if (error_count == errors_before) begin
         pass_count++;
         $display("test %s passed", name);
      end else begin
         fail_count++;
         $display("test %s failed", name);
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      int                      fd;
      int                      n_fields;
      string                   line;
      string                   name;
      string                   kind;
      logic [`IOB_ADDR_W-1:0]  addr;
      logic [`IOB_DATA_W-1:0]  wdata;
      logic [`IOB_STRB_W-1:0]  strb;
      logic [`IOB_DATA_W-1:0]  expected;
      logic [1:0]              gap;
      logic                    timed_out;
      reset   = 1'b1;
      m_valid = 1'b0;
      m_addr  = '0;
      m_wdata = '0;
      m_wstrb = '0;
      timed_out = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      reset = 1'b0;
      @(posedge clk);
      #DRIVE_DLY;
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
         $display("cannot open case file %s", CASE_FILE);
         error_count++;
      end else begin
         while (!timed_out && !$feof(fd)) begin
            line = "";
            // Skip blank and comment lines
            if ($fgets(line, fd) != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
               n_fields = $sscanf(line, "%s %s %h %h %h %h",
                                  name, kind, addr, wdata, strb, expected);
               if (n_fields != 6 || (kind != "R" && kind != "W")) begin
                  $display("malformed line in case file: %s", line);
                  error_count++;
               end else begin
                  run_case(name, kind, addr, wdata, strb, expected, timed_out);
                  // Idle gap of 0 to 3 cycles after the ready cycle
                  gap[1] = lfsr_bit();
                  gap[0] = lfsr_bit();
                  repeat (int'(gap) + 1) begin
                     @(posedge clk);
                     #DRIVE_DLY;
                  end
               end
            end
         end
         $fclose(fd);
      end
      if (pass_count + fail_count == 0) begin
         $display("no test cases were run");
         error_count++;
      end
      // Failures caught by the bound checker
      if (dut_i.chk_i.assert_fails != 0) begin
         $display("interconnect checker saw %0d assertion failures",
                  dut_i.chk_i.assert_fails);
         error_count++;
      end
      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+logic
logic/iob_ic_pkg.sv
logic/iob_addr_decoder.sv
logic/iob_req_fanout.sv
logic/iob_resp_mux.sv
logic/iob_sram_slave.sv
logic/iob_interconnect_top.sv
bench/iob_ic_chk.sv
bench/iob_ic_tb.sv

/* Makefile */
# Verilator build and run for the interconnect testbench

VERILATOR ?= verilator
TOP       ?= iob_ic_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/iob_ic_cases.txt */
# name kind(R/W) addr wdata strobes expected_rdata, all hex
# Slave index is addr[31:30], expected_rdata is unused on writes
rd_rst_s0     R 00000000 00000000 0 00000000
rd_rst_s1     R 40000000 00000000 0 00000000
rd_rst_s2     R 80000000 00000000 0 00000000
rd_rst_s3     R c0000000 00000000 0 00000000
wr_full_s0    W 00000004 11223344 f 00000000
rd_full_s0    R 00000004 00000000 0 11223344
wr_full_s1    W 40000004 a5a5a5a5 f 00000000
rd_full_s1    R 40000004 00000000 0 a5a5a5a5
wr_full_s2    W 80000004 deadbeef f 00000000
rd_full_s2    R 80000004 00000000 0 deadbeef
wr_full_s3    W c0000004 cafef00d f 00000000
rd_full_s3    R c0000004 00000000 0 cafef00d
wr_part_base  W 80000008 01234567 f 00000000
wr_part_b0b2  W 80000008 aabbccdd 5 00000000
rd_part_b0b2  R 80000008 00000000 0 01bb45dd
wr_part_b3    W 80000008 99887766 8 00000000
rd_part_b3    R 80000008 00000000 0 99bb45dd
wr_same_s0    W 0000000c 00000a00 f 00000000
wr_same_s1    W 4000000c 00000b11 f 00000000
wr_same_s2    W 8000000c 00000c22 f 00000000
wr_same_s3    W c000000c 00000d33 f 00000000
rd_same_s0    R 0000000c 00000000 0 00000a00
rd_same_s1    R 4000000c 00000000 0 00000b11
rd_same_s2    R 8000000c 00000000 0 00000c22
rd_same_s3    R c000000c 00000000 0 00000d33
b2b_wr_fast   W 00000010 5a5a0001 f 00000000
b2b_wr_slow   W c0000010 5a5a0003 f 00000000
b2b_rd_fast   R 00000010 00000000 0 5a5a0001
b2b_rd_slow   R c0000010 00000000 0 5a5a0003
